//--- common/fetch_cfg.svh
/*
 * fetch queue sizing macros
 * queue depth and datapath width
 */

`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// ------------------------------------------------------------
// datapath
// ------------------------------------------------------------

// pc and data width
`define XLEN 32

// ------------------------------------------------------------
// fetch queue
// ------------------------------------------------------------

// entries waiting between fetch and issue
`define FQ_DEPTH 4

`endif

//--- common/instr_pkg.sv
/*
 * instruction encoding: opcode constants, r/i format views,
 * instruction union and fetch queue entry
 */

`default_nettype none

`include "fetch_cfg.svh"

package instr_pkg;

  // ------------------------------------------------------------
  // opcodes
  // ------------------------------------------------------------

  typedef logic [5:0] opcode_t;

  localparam opcode_t OP_RTYPE = 6'd0;
  // i-format alu ops
  localparam opcode_t OP_ADDI  = 6'd8;
  localparam opcode_t OP_ANDI  = 6'd12;
  localparam opcode_t OP_ORI   = 6'd13;
  localparam opcode_t OP_XORI  = 6'd14;
  // memory ops, also i-format
  localparam opcode_t OP_LOAD  = 6'd35;
  localparam opcode_t OP_STORE = 6'd43;

  // ------------------------------------------------------------
  // instruction formats
  // ------------------------------------------------------------

  // register-register form
  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [10:0] funct;
  } r_fmt_t;

  // register-immediate form
  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [15:0] imm;
  } i_fmt_t;

  // same 32-bit word, two field layouts
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_t;

  // one fetch queue slot
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    instr_t           instr;
  } fq_entry_t;

endpackage

`default_nettype wire

//--- common/uop_pkg.sv
/*
 * decoded micro-op: alu operation enum and micro-op struct
 */

`default_nettype none

`include "fetch_cfg.svh"

package uop_pkg;

  // ------------------------------------------------------------
  // alu operations
  // ------------------------------------------------------------

  // ALU_NONE marks illegal encodings
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_NONE = 3'd5
  } alu_op_e;

  // ------------------------------------------------------------
  // micro-op
  // ------------------------------------------------------------

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    alu_op_e          alu_op;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    // already sign-extended
    logic [`XLEN-1:0] imm;
    logic             use_imm;
    logic             is_load;
    logic             is_store;
    logic             illegal;
  } uop_t;

endpackage

`default_nettype wire

//--- common/fq_if.sv
/*
 * fetch queue to issue side link
 * head entry, empty level and pop strobe
 */

`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

interface fq_if;
  import instr_pkg::*;

  // head of queue valid only while empty is low
  logic             empty;
  logic [`XLEN-1:0] rdata_pc;
  instr_t           rdata_instr;
  // issue side removes the head
  logic             pop;

  // queue drives status and head data
  modport queue (output empty, output rdata_pc, output rdata_instr);

  // issue side watches the head and pops
  modport issue (input empty, input rdata_pc, input rdata_instr, output pop);

endinterface

`default_nettype wire

//--- rtl/fifo/fifo.sv
/*
 * first-word-fall-through fifo, generic entry type and depth
 * circular buffer with count, registered empty/full levels
 */

`timescale 1ns/1ps
`default_nettype none

module fifo #(
  parameter type         t_entry = logic [31:0],
  parameter int unsigned p_depth = 4
) (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   push,
  input  logic   pop,
  input  t_entry wdata,
  output logic   full,
  fq_if.queue    q
);

  // pointer needs one bit even for a single entry
  localparam int PTR_W = (p_depth > 1) ? $clog2(p_depth) : 1;
  localparam int CNT_W = $clog2(p_depth + 1);

  // ------------------------------------------------------------
  // storage and state
  // ------------------------------------------------------------

  t_entry             mem [p_depth];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic [CNT_W-1:0]   count_next;
  logic               empty_q;
  logic               full_q;
  logic               do_push;
  logic               do_pop;
  t_entry             head;

  // strobes judged on pre-edge levels
  assign do_push = push & ~full_q;
  assign do_pop  = pop  & ~empty_q;

  always_comb begin
    case ({do_push, do_pop})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      // push+pop or idle keeps the count
      default: count_next = count;
    endcase
  end

  // ------------------------------------------------------------
  // pointers, count, flags
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      empty_q <= 1'b1;
      full_q  <= 1'b0;
    end else begin
      if (do_push) begin
        // wrap at last slot
        if (wr_ptr == PTR_W'(p_depth - 1)) wr_ptr <= '0;
        else wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        if (rd_ptr == PTR_W'(p_depth - 1)) rd_ptr <= '0;
        else rd_ptr <= rd_ptr + 1'b1;
      end
      count   <= count_next;
      // flags registered from the next count
      empty_q <= (count_next == '0);
      full_q  <= (count_next == CNT_W'(p_depth));
    end
  end

  // payload only, no reset
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wdata;
  end

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------

  // head falls through as soon as it is written
  assign head = mem[rd_ptr];
  assign {q.rdata_pc, q.rdata_instr} = head;
  assign q.empty = empty_q;
  assign full    = full_q;

endmodule

`default_nettype wire

//--- rtl/decode/instr_decoder.sv
/*
 * combinational instruction decoder
 * word + pc to micro-op, sign extension, store remap, illegal flag
 */

`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module instr_decoder (
  input  logic [`XLEN-1:0] pc,
  input  instr_pkg::instr_t instr,
  output uop_pkg::uop_t    uop
);
  import instr_pkg::*;
  import uop_pkg::*;

  logic [`XLEN-1:0] imm_sext;
  alu_op_e          r_op;
  logic             r_legal;

  // i-format immediate, sign bit 15 replicated
  assign imm_sext = {{(`XLEN - 16){instr.i_fmt.imm[15]}}, instr.i_fmt.imm};

  // r-format op from low funct bits
  always_comb begin
    r_legal = 1'b1;
    case (instr.r_fmt.funct[2:0])
      3'd0:    r_op = ALU_ADD;
      3'd1:    r_op = ALU_SUB;
      3'd2:    r_op = ALU_AND;
      3'd3:    r_op = ALU_OR;
      3'd4:    r_op = ALU_XOR;
      default: begin
        r_op    = ALU_NONE;
        r_legal = 1'b0;
      end
    endcase
  end

  // ------------------------------------------------------------
  // field selection by opcode
  // ------------------------------------------------------------

  always_comb begin
    // illegal shape by default, pc always kept
    uop         = '0;
    uop.pc      = pc;
    uop.alu_op  = ALU_NONE;
    uop.illegal = 1'b1;
    case (instr.r_fmt.opcode)
      OP_RTYPE: begin
        if (r_legal) begin
          uop.alu_op  = r_op;
          uop.rd      = instr.r_fmt.rd;
          uop.rs1     = instr.r_fmt.rs1;
          uop.rs2     = instr.r_fmt.rs2;
          uop.illegal = 1'b0;
        end
      end
      OP_ADDI, OP_ANDI, OP_ORI, OP_XORI: begin
        case (instr.i_fmt.opcode)
          OP_ANDI: uop.alu_op = ALU_AND;
          OP_ORI:  uop.alu_op = ALU_OR;
          OP_XORI: uop.alu_op = ALU_XOR;
          default: uop.alu_op = ALU_ADD;
        endcase
        uop.rd      = instr.i_fmt.rd;
        uop.rs1     = instr.i_fmt.rs1;
        uop.imm     = imm_sext;
        uop.use_imm = 1'b1;
        uop.illegal = 1'b0;
      end
      OP_LOAD: begin
        // address = rs1 + imm
        uop.alu_op  = ALU_ADD;
        uop.rd      = instr.i_fmt.rd;
        uop.rs1     = instr.i_fmt.rs1;
        uop.imm     = imm_sext;
        uop.use_imm = 1'b1;
        uop.is_load = 1'b1;
        uop.illegal = 1'b0;
      end
      OP_STORE: begin
        // rd slot names the data source, no destination
        uop.alu_op   = ALU_ADD;
        uop.rs1      = instr.i_fmt.rs1;
        uop.rs2      = instr.i_fmt.rd;
        uop.imm      = imm_sext;
        uop.use_imm  = 1'b1;
        uop.is_store = 1'b1;
        uop.illegal  = 1'b0;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/decode/uop_issue_reg.sv
/*
 * issue register: one decoded micro-op plus valid
 * pops the fetch queue whenever the slot frees up
 */

`timescale 1ns/1ps
`default_nettype none

module uop_issue_reg (
  input  logic          clk,
  input  logic          arst_n,
  fq_if.issue           q,
  input  uop_pkg::uop_t uop_next,
  input  logic          take,
  output logic          valid,
  output uop_pkg::uop_t uop
);
  import uop_pkg::*;

  // ------------------------------------------------------------
  // load condition
  // ------------------------------------------------------------

  logic   load;
  logic   valid_q;
  uop_t   uop_q;

  // slot free now, or emptied by take this cycle
  assign load  = ~q.empty & (~valid_q | take);
  // pop in the same cycle as the load
  assign q.pop = load;

  // ------------------------------------------------------------
  // valid flag
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (take) begin
      // taken with nothing behind it
      valid_q <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // micro-op payload
  // ------------------------------------------------------------

  // holds steady under back-pressure
  always_ff @(posedge clk) begin
    if (load) uop_q <= uop_next;
  end

  assign valid = valid_q;
  assign uop   = uop_q;

endmodule

`default_nettype wire

//--- rtl/fetch_decode_top.sv
/*
 * fetch-to-decode stage top: fetch queue, decoder, issue register
 * micro-op flattened onto plain ports
 */

`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_decode_top (
  input  logic             clk,
  input  logic             arst_n,
  // fetch side
  input  logic             fetch_push,
  input  logic [31:0]      fetch_pc,
  input  logic [31:0]      fetch_instr,
  output logic             fetch_full,
  // issue side
  input  logic             uop_take,
  output logic             uop_valid,
  output logic [31:0]      uop_pc,
  output logic [2:0]       uop_alu_op,
  output logic [4:0]       uop_rd,
  output logic [4:0]       uop_rs1,
  output logic [4:0]       uop_rs2,
  output logic [31:0]      uop_imm,
  output logic             uop_use_imm,
  output logic             uop_is_load,
  output logic             uop_is_store,
  output logic             uop_illegal
);
  import instr_pkg::*;
  import uop_pkg::*;

  fq_entry_t fetch_entry;
  uop_t      uop_dec;
  uop_t      uop_out;

  fq_if fq ();

  // pack fetch inputs into one queue slot
  assign fetch_entry.pc    = fetch_pc;
  assign fetch_entry.instr = fetch_instr;

  // ------------------------------------------------------------
  // fetch queue
  // ------------------------------------------------------------

  fifo #(
    .t_entry (fq_entry_t),
    .p_depth (`FQ_DEPTH)
  ) fifo_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .push   (fetch_push),
    .pop    (fq.pop),
    .wdata  (fetch_entry),
    .full   (fetch_full),
    .q      (fq.queue)
  );

  // decode straight off the queue head
  instr_decoder instr_decoder_inst (
    .pc    (fq.rdata_pc),
    .instr (fq.rdata_instr),
    .uop   (uop_dec)
  );

  uop_issue_reg uop_issue_reg_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .q        (fq.issue),
    .uop_next (uop_dec),
    .take     (uop_take),
    .valid    (uop_valid),
    .uop      (uop_out)
  );

  // ------------------------------------------------------------
  // flatten micro-op
  // ------------------------------------------------------------

  assign uop_pc       = uop_out.pc;
  assign uop_alu_op   = uop_out.alu_op;
  assign uop_rd       = uop_out.rd;
  assign uop_rs1      = uop_out.rs1;
  assign uop_rs2      = uop_out.rs2;
  assign uop_imm      = uop_out.imm;
  assign uop_use_imm  = uop_out.use_imm;
  assign uop_is_load  = uop_out.is_load;
  assign uop_is_store = uop_out.is_store;
  assign uop_illegal  = uop_out.illegal;

endmodule

`default_nettype wire

//--- testbench/tb_fetch_decode.sv
/*
 * testbench for the fetch-to-decode stage
 * vector file reader, reference queue model, back-pressure and random traffic
 */

`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module tb_fetch_decode;

  localparam int MAX_VEC  = 32;
  // pc, alu_op, rd, rs1, rs2, imm, four flags
  localparam int UOP_W    = 86;
  localparam int WAIT_MAX = 100;

  logic        clk;
  logic        arst_n;
  logic        fetch_push;
  logic [31:0] fetch_pc;
  logic [31:0] fetch_instr;
  logic        fetch_full;
  logic        uop_take;
  logic        uop_valid;
  logic [31:0] uop_pc;
  logic [2:0]  uop_alu_op;
  logic [4:0]  uop_rd;
  logic [4:0]  uop_rs1;
  logic [4:0]  uop_rs2;
  logic [31:0] uop_imm;
  logic        uop_use_imm;
  logic        uop_is_load;
  logic        uop_is_store;
  logic        uop_illegal;

  // vectors from the data file
  logic [31:0]      vec_pc    [MAX_VEC];
  logic [31:0]      vec_instr [MAX_VEC];
  logic [UOP_W-1:0] vec_uop   [MAX_VEC];
  int               n_vec;

  // expected micro-ops in push order
  logic [UOP_W-1:0] model_q [$];
  int               drive_idx;
  int               taken_cnt;
  bit               last_accepted;
  logic [31:0]      rng_state;

  fetch_decode_top fetch_decode_top_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .fetch_push   (fetch_push),
    .fetch_pc     (fetch_pc),
    .fetch_instr  (fetch_instr),
    .fetch_full   (fetch_full),
    .uop_take     (uop_take),
    .uop_valid    (uop_valid),
    .uop_pc       (uop_pc),
    .uop_alu_op   (uop_alu_op),
    .uop_rd       (uop_rd),
    .uop_rs1      (uop_rs1),
    .uop_rs2      (uop_rs2),
    .uop_imm      (uop_imm),
    .uop_use_imm  (uop_use_imm),
    .uop_is_load  (uop_is_load),
    .uop_is_store (uop_is_store),
    .uop_illegal  (uop_illegal)
  );

  // 10 ns period
  always #5 clk = ~clk;

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // dut outputs in the same layout as vec_uop
  function automatic logic [UOP_W-1:0] dut_uop();
    return {uop_pc, uop_alu_op, uop_rd, uop_rs1, uop_rs2, uop_imm,
            uop_use_imm, uop_is_load, uop_is_store, uop_illegal};
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_pc;
    logic [31:0] f_instr;
    logic [31:0] f_alu;
    logic [31:0] f_rd;
    logic [31:0] f_rs1;
    logic [31:0] f_rs2;
    logic [31:0] f_imm;
    logic [31:0] f_use;
    logic [31:0] f_ld;
    logic [31:0] f_st;
    logic [31:0] f_ill;
    n_vec = 0;
    fd = $fopen("testbench/fetch_decode_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the test vector file");
    end else begin
      while (!$feof(fd) && n_vec < MAX_VEC) begin
        line = "";
        void'($fgets(line, fd));
        // skip blank and comment lines
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f_pc, f_instr,
                      f_alu, f_rd, f_rs1, f_rs2, f_imm, f_use, f_ld, f_st, f_ill);
          if (n == 11) begin
            vec_pc[n_vec]    = f_pc;
            vec_instr[n_vec] = f_instr;
            vec_uop[n_vec]   = {f_pc, f_alu[2:0], f_rd[4:0], f_rs1[4:0], f_rs2[4:0],
                                f_imm, f_use[0], f_ld[0], f_st[0], f_ill[0]};
            n_vec++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ------------------------------------------------------------
  // cycle driver and model
  // ------------------------------------------------------------

  // runs at the falling edge, before the edge that acts on the strobes
  task automatic track();
    last_accepted = 1'b0;
    if (uop_valid) begin
      assert (model_q.size() > 0)
        else abort_run("micro-op valid while the model expects nothing");
      assert (dut_uop() === model_q[0])
        else abort_run($sformatf("mismatch at %0t: micro-op got %h expected %h",
                                 $time, dut_uop(), model_q[0]));
      if (uop_take) begin
        void'(model_q.pop_front());
        taken_cnt++;
      end
    end
    // full is a registered level, so this is the accept decision
    if (fetch_push && !fetch_full) begin
      model_q.push_back(vec_uop[drive_idx]);
      last_accepted = 1'b1;
    end
    assert (model_q.size() <= `FQ_DEPTH + 1)
      else abort_run("more items in flight than the queue and issue slot can hold");
  endtask

  task automatic drive(input logic push, input int idx, input logic take);
    @(posedge clk);
    fetch_push  <= push;
    fetch_pc    <= vec_pc[idx];
    fetch_instr <= vec_instr[idx];
    uop_take    <= take;
    drive_idx    = idx;
    @(negedge clk);
    track();
  endtask

  task automatic drain();
    int guard;
    guard = 0;
    while (model_q.size() > 0 && guard < WAIT_MAX) begin
      drive(1'b0, 0, 1'b1);
      guard++;
    end
    assert (model_q.size() == 0) else abort_run("timeout while draining the stage");
    drive(1'b0, 0, 1'b0);
    assert (!uop_valid) else abort_run("micro-op still valid after the stage drained");
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------

  initial begin
    int               idx;
    int               guard;
    int               base;
    int               round;
    logic             take;
    logic [UOP_W-1:0] held;
    clk         = 1'b0;
    arst_n      = 1'b0;
    fetch_push  = 1'b0;
    fetch_pc    = '0;
    fetch_instr = '0;
    uop_take    = 1'b0;
    taken_cnt   = 0;
    drive_idx   = 0;
    rng_state   = 32'd66;
    load_vectors();
    assert (n_vec >= `FQ_DEPTH + 2) else abort_run("too few vectors in the data file");

    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    assert (!fetch_full && !uop_valid) else abort_run("full or valid set after reset");

    // single push, valid after the edge that follows the accepting one
    drive(1'b1, 0, 1'b0);
    drive(1'b0, 0, 1'b0);
    assert (!uop_valid) else abort_run("micro-op valid only one edge after the push");
    drive(1'b0, 0, 1'b0);
    assert (uop_valid) else abort_run("micro-op not valid two edges after the push");
    assert (dut_uop() === vec_uop[0])
      else abort_run($sformatf("mismatch at %0t: first micro-op got %h expected %h",
                               $time, dut_uop(), vec_uop[0]));
    drain();

    // every vector streamed with take held high
    base = taken_cnt;
    for (idx = 0; idx < n_vec; idx++) begin
      drive(1'b1, idx, 1'b1);
    end
    drain();
    assert (taken_cnt - base == n_vec) else abort_run("not every vector left the stage");

    // back-pressure, fill until full
    idx   = 0;
    guard = 0;
    while (!fetch_full && guard < WAIT_MAX) begin
      drive(1'b1, idx % n_vec, 1'b0);
      idx++;
      guard++;
    end
    assert (fetch_full) else abort_run("timeout waiting for the queue to fill");
    assert (model_q.size() == `FQ_DEPTH + 1)
      else abort_run($sformatf("mismatch at %0t: %0d items in flight, expected %0d",
                               $time, model_q.size(), `FQ_DEPTH + 1));
    held = dut_uop();
    // pushes while full are dropped, held micro-op unchanged
    repeat (3) begin
      drive(1'b1, idx % n_vec, 1'b0);
      assert (fetch_full && dut_uop() === held)
        else abort_run($sformatf("mismatch at %0t: held micro-op %h changed to %h",
                                 $time, held, dut_uop()));
    end
    drain();

    // random traffic, three take densities
    for (round = 0; round < 3; round++) begin
      idx   = 0;
      guard = 0;
      while (idx < n_vec && guard < 50 * n_vec) begin
        rng_state = xorshift(rng_state);
        case (round)
          0:       take = rng_state[2];
          1:       take = rng_state[2] & rng_state[3];
          default: take = rng_state[2] | rng_state[3];
        endcase
        drive(rng_state[0] | rng_state[1], idx, take);
        // refetch the same word until the queue takes it
        if (last_accepted) idx++;
        guard++;
      end
      assert (idx == n_vec) else abort_run("timeout feeding vectors in random traffic");
      drain();
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/fetch_decode_testdata.txt
# columns (hex): pc instr alu_op rd rs1 rs2 imm use_imm is_load is_store illegal
# alu_op: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 none
00001000 00221800 0 01 02 03 00000000 0 0 0 0
00001004 00853001 1 04 05 06 00000000 0 0 0 0
00001008 00e84802 2 07 08 09 00000000 0 0 0 0
0000100c 03fee803 3 1f 1e 1d 00000000 0 0 0 0
00001010 014b6004 4 0a 0b 0c 00000000 0 0 0 0
00001014 004327f8 0 02 03 04 00000000 0 0 0 0
00001018 00210805 5 00 00 00 00000000 0 0 0 1
0000101c 00210807 5 00 00 00 00000000 0 0 0 1
00001020 20200005 0 01 00 00 00000005 1 0 0 0
00001024 2064ffff 0 03 04 00 ffffffff 1 0 0 0
00001028 30a68000 2 05 06 00 ffff8000 1 0 0 0
0000102c 34e87fff 3 07 08 00 00007fff 1 0 0 0
00001030 392aff00 4 09 0a 00 ffffff00 1 0 0 0
00001034 8d6c0010 0 0b 0c 00 00000010 1 1 0 0
00001038 8daefffc 0 0d 0e 00 fffffffc 1 1 0 0
0000103c adf00020 0 00 10 0f 00000020 1 0 1 0
00001040 afe1fff8 0 00 01 1f fffffff8 1 0 1 0
00001044 04221234 5 00 00 00 00000000 0 0 0 1
00001048 fcffffff 5 00 00 00 00000000 0 0 0 1
0000104c 24431234 5 00 00 00 00000000 0 0 0 1

//--- src.f
+incdir+common
common/instr_pkg.sv
common/uop_pkg.sv
common/fq_if.sv
rtl/fifo/fifo.sv
rtl/decode/instr_decoder.sv
rtl/decode/uop_issue_reg.sv
rtl/fetch_decode_top.sv
testbench/tb_fetch_decode.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch-to-decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

verilator --binary --timing --assert -f src.f --top-module tb_fetch_decode -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

OUTPUT=$("./$BUILD_DIR/Vtb_fetch_decode" 2>&1)
STATUS=$?
echo "$OUTPUT"

if [ $STATUS -ne 0 ]; then
  echo "simulation exited with status $STATUS"
  exit 1
fi

if echo "$OUTPUT" | grep -qx "=== PASS ==="; then
  echo "simulation passed"
  exit 0
else
  echo "simulation did not report success"
  exit 1
fi
